/* sramtest_settings.svh */
`ifndef SRAMTEST_SETTINGS_SVH
`define SRAMTEST_SETTINGS_SVH

// number of sram macros sharing the two ports
`define SRAMTEST_NUM_CHIPS 8

// chip-select field, wide enough to index every macro
`define SRAMTEST_SELECT_SIZE 3

// per-port field widths
`define SRAMTEST_ADDR_SIZE 8
`define SRAMTEST_DATA_SIZE 32
`define SRAMTEST_WMASK_SIZE 4 // one bit per byte of data

`endif

/* sramtest_pkg.sv */
`include "sramtest_settings.svh"

package sramtest_pkg;

	// addr + din + wmask + csb + web
	localparam int PORT_SIZE = `SRAMTEST_ADDR_SIZE + `SRAMTEST_DATA_SIZE +
		`SRAMTEST_WMASK_SIZE + 2;

	// chip select followed by port0 and port1
	localparam int TOTAL_SIZE = `SRAMTEST_SELECT_SIZE + 2 * PORT_SIZE;

	// one port of the command register, msb first
	typedef struct packed {
		logic [`SRAMTEST_ADDR_SIZE-1:0]  addr;
		logic [`SRAMTEST_DATA_SIZE-1:0]  din;
		logic                            csb;   // active low
		logic                            web;   // active low write enable
		logic [`SRAMTEST_WMASK_SIZE-1:0] wmask;
	} port_field_t;

	// full command register as seen on the la bus and the scan chain
	typedef struct packed {
		logic [`SRAMTEST_SELECT_SIZE-1:0] chip_select;
		port_field_t                      port0;
		port_field_t                      port1;
	} cmd_reg_t;

	// read data of every macro for one port
	typedef logic [`SRAMTEST_NUM_CHIPS-1:0][`SRAMTEST_DATA_SIZE-1:0] chip_data_t;

	// one active-low select per macro
	typedef logic [`SRAMTEST_NUM_CHIPS-1:0] chip_csb_t;

	// what the command register does on the next edge
	typedef enum logic [1:0] {
		op_hold,
		op_scan,
		op_load,
		op_capture
	} reg_op_t;

endpackage

/* sramtest_ctrl.sv */
`timescale 1ns/1ps

`include "sramtest_settings.svh"

module sramtest_ctrl (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   gpio_in_i,        // serial scan data
	input  logic                   gpio_scan_i,
	input  logic                   la_in_load_i,
	input  logic                   gpio_sram_load_i,
	input  logic                   la_sram_load_i,
	input  sramtest_pkg::cmd_reg_t la_data_i,
	input  sramtest_pkg::cmd_reg_t capture_d_i,      // register with read data merged in
	output sramtest_pkg::cmd_reg_t cmd_q_o
);

	import sramtest_pkg::*;

	reg_op_t  op;
	cmd_reg_t cmd_q;
	logic     capture_req;

	// either strobe requests a capture of the read data
	assign capture_req = gpio_sram_load_i | la_sram_load_i;

	// fixed priority: scan, then la load, then capture
	always_comb begin
		if (gpio_scan_i) begin
			op = op_scan;
		end else if (la_in_load_i) begin
			op = op_load;
		end else if (capture_req) begin
			op = op_capture;
		end else begin
			op = op_hold;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cmd_q <= '0;
		end else begin
			case (op)
				op_scan:    cmd_q <= {cmd_q[TOTAL_SIZE-2:0], gpio_in_i}; // shift toward msb
				op_load:    cmd_q <= la_data_i;
				op_capture: cmd_q <= capture_d_i;
				default:    cmd_q <= cmd_q;
			endcase
		end
	end

	assign cmd_q_o = cmd_q;

	// the strobes come straight off pads, an x here would pick a random branch
	a_strobe_known: assert property (
		@(posedge clk) disable iff (!resetn)
		!$isunknown({gpio_scan_i, la_in_load_i, gpio_sram_load_i, la_sram_load_i})
	) else $error("sramtest_ctrl: unknown strobe");

	// an x shifted in would travel through every field and reach the sram controls
	a_scan_data_known: assert property (
		@(posedge clk) disable iff (!resetn)
		(op == op_scan) |-> !$isunknown(gpio_in_i)
	) else $error("sramtest_ctrl: unknown scan data");

endmodule

/* sram_port_drive.sv */
`timescale 1ns/1ps

`include "sramtest_settings.svh"

module sram_port_drive (
	input  sramtest_pkg::port_field_t        field_i,
	input  logic [`SRAMTEST_SELECT_SIZE-1:0] chip_select_i,
	input  logic                             global_csb_i,   // forces every macro off
	output logic [`SRAMTEST_ADDR_SIZE-1:0]   addr_o,
	output logic [`SRAMTEST_DATA_SIZE-1:0]   din_o,
	output logic                             web_o,
	output logic [`SRAMTEST_WMASK_SIZE-1:0]  wmask_o,
	output sramtest_pkg::chip_csb_t          csb_o
);

	import sramtest_pkg::*;

	logic      csb_eff;
	chip_csb_t csb_vec;

	// shared lines go to every macro unchanged
	assign addr_o  = field_i.addr;
	assign din_o   = field_i.din;
	assign web_o   = field_i.web;
	assign wmask_o = field_i.wmask;

	// either select being high keeps the chosen macro idle
	assign csb_eff = field_i.csb | global_csb_i;

	// all macros inactive except the chosen one, which gets the gated select
	always_comb begin
		csb_vec = '1;
		csb_vec[chip_select_i] = csb_eff;
	end

	assign csb_o = csb_vec;

endmodule

/* read_capture_mux.sv */
`timescale 1ns/1ps

`include "sramtest_settings.svh"

module read_capture_mux (
	input  sramtest_pkg::cmd_reg_t   cmd_q_i,
	input  sramtest_pkg::chip_data_t sram_data0_i,  // port 0 read data, one word per macro
	input  sramtest_pkg::chip_data_t sram_data1_i,  // port 1 read data, one word per macro
	output sramtest_pkg::cmd_reg_t   capture_d_o
);

	import sramtest_pkg::*;

	logic [`SRAMTEST_SELECT_SIZE-1:0] sel;
	logic [`SRAMTEST_DATA_SIZE-1:0]   read_data0;
	logic [`SRAMTEST_DATA_SIZE-1:0]   read_data1;
	cmd_reg_t                         capture_d;

	// same macro as the one the csb vectors point at
	assign sel = cmd_q_i.chip_select;

	// read word of the selected macro, per port
	assign read_data0 = sram_data0_i[sel];
	assign read_data1 = sram_data1_i[sel];

	// read data lands in the din fields so it can be shifted or read out
	// over the la bus, everything else is kept as it was
	always_comb begin
		capture_d           = cmd_q_i;
		capture_d.port0.din = read_data0;
		capture_d.port1.din = read_data1;
	end

	assign capture_d_o = capture_d;

endmodule

/* sramtest_top.sv */
`timescale 1ns/1ps

`include "sramtest_settings.svh"

module sramtest_top (
	input  logic                             clk,
	input  logic                             resetn,
	// serial scan from gpio
	input  logic                             gpio_in_i,
	input  logic                             gpio_scan_i,
	input  logic                             gpio_sram_load_i,
	// parallel access from the logic analyzer
	input  logic                             la_in_load_i,
	input  logic                             la_sram_load_i,
	input  sramtest_pkg::cmd_reg_t           la_data_i,
	input  logic                             global_csb_i,
	// read data from each macro
	input  sramtest_pkg::chip_data_t         sram_data0_i,
	input  sramtest_pkg::chip_data_t         sram_data1_i,
	// shared port 0
	output logic [`SRAMTEST_ADDR_SIZE-1:0]   addr0_o,
	output logic [`SRAMTEST_DATA_SIZE-1:0]   din0_o,
	output logic                             web0_o,
	output logic [`SRAMTEST_WMASK_SIZE-1:0]  wmask0_o,
	output sramtest_pkg::chip_csb_t          csb0_o,
	// shared port 1
	output logic [`SRAMTEST_ADDR_SIZE-1:0]   addr1_o,
	output logic [`SRAMTEST_DATA_SIZE-1:0]   din1_o,
	output logic                             web1_o,
	output logic [`SRAMTEST_WMASK_SIZE-1:0]  wmask1_o,
	output sramtest_pkg::chip_csb_t          csb1_o,
	// readout
	output sramtest_pkg::cmd_reg_t           la_data_o,
	output logic                             gpio_o
);

	import sramtest_pkg::*;

	cmd_reg_t cmd_q;
	cmd_reg_t capture_d;

	sramtest_ctrl u_ctrl (
		.clk              (clk),
		.resetn           (resetn),
		.gpio_in_i        (gpio_in_i),
		.gpio_scan_i      (gpio_scan_i),
		.la_in_load_i     (la_in_load_i),
		.gpio_sram_load_i (gpio_sram_load_i),
		.la_sram_load_i   (la_sram_load_i),
		.la_data_i        (la_data_i),
		.capture_d_i      (capture_d),
		.cmd_q_o          (cmd_q)
	);

	sram_port_drive u_port0 (
		.field_i       (cmd_q.port0),
		.chip_select_i (cmd_q.chip_select),
		.global_csb_i  (global_csb_i),
		.addr_o        (addr0_o),
		.din_o         (din0_o),
		.web_o         (web0_o),
		.wmask_o       (wmask0_o),
		.csb_o         (csb0_o)
	);

	sram_port_drive u_port1 (
		.field_i       (cmd_q.port1),
		.chip_select_i (cmd_q.chip_select), // both ports address the same macro
		.global_csb_i  (global_csb_i),
		.addr_o        (addr1_o),
		.din_o         (din1_o),
		.web_o         (web1_o),
		.wmask_o       (wmask1_o),
		.csb_o         (csb1_o)
	);

	read_capture_mux u_capture (
		.cmd_q_i      (cmd_q),
		.sram_data0_i (sram_data0_i),
		.sram_data1_i (sram_data1_i),
		.capture_d_o  (capture_d)
	);

	// serial readout shifts out of the msb while new bits enter at bit 0
	assign gpio_o    = cmd_q[TOTAL_SIZE-1];
	assign la_data_o = cmd_q;

endmodule

/* tb_sramtest.sv */
`timescale 1ns/1ps

`include "sramtest_settings.svh"

module tb_sramtest;

	import sramtest_pkg::*;

	localparam int CYCLE_LIMIT = 2000; // about 600 cycles of stimulus plus margin

	logic       clk;
	logic       resetn;
	logic       gpio_in_i;
	logic       gpio_scan_i;
	logic       gpio_sram_load_i;
	logic       la_in_load_i;
	logic       la_sram_load_i;
	cmd_reg_t   la_data_i;
	logic       global_csb_i;
	chip_data_t sram_data0_i;
	chip_data_t sram_data1_i;

	logic [`SRAMTEST_ADDR_SIZE-1:0]  addr0_o;
	logic [`SRAMTEST_DATA_SIZE-1:0]  din0_o;
	logic                            web0_o;
	logic [`SRAMTEST_WMASK_SIZE-1:0] wmask0_o;
	chip_csb_t                       csb0_o;
	logic [`SRAMTEST_ADDR_SIZE-1:0]  addr1_o;
	logic [`SRAMTEST_DATA_SIZE-1:0]  din1_o;
	logic                            web1_o;
	logic [`SRAMTEST_WMASK_SIZE-1:0] wmask1_o;
	chip_csb_t                       csb1_o;
	cmd_reg_t                        la_data_o;
	logic                            gpio_o;

	cmd_reg_t              model_q;    // reference copy of the command register
	chip_csb_t             exp_csb0;
	chip_csb_t             exp_csb1;
	logic [TOTAL_SIZE-1:0] scan_hist;  // newest scanned bit at index 0
	int                    scan_run;   // consecutive scan edges
	int                    cycle_count;

	sramtest_top i_dut (
		.clk              (clk),
		.resetn           (resetn),
		.gpio_in_i        (gpio_in_i),
		.gpio_scan_i      (gpio_scan_i),
		.gpio_sram_load_i (gpio_sram_load_i),
		.la_in_load_i     (la_in_load_i),
		.la_sram_load_i   (la_sram_load_i),
		.la_data_i        (la_data_i),
		.global_csb_i     (global_csb_i),
		.sram_data0_i     (sram_data0_i),
		.sram_data1_i     (sram_data1_i),
		.addr0_o          (addr0_o),
		.din0_o           (din0_o),
		.web0_o           (web0_o),
		.wmask0_o         (wmask0_o),
		.csb0_o           (csb0_o),
		.addr1_o          (addr1_o),
		.din1_o           (din1_o),
		.web1_o           (web1_o),
		.wmask1_o         (wmask1_o),
		.csb1_o           (csb1_o),
		.la_data_o        (la_data_o),
		.gpio_o           (gpio_o)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic logic random_bit();
		logic [31:0] r;
		r = $urandom;
		return r[0];
	endfunction

	function automatic cmd_reg_t random_cmd();
		logic [95:0] r;
		r = {$urandom, $urandom, $urandom};
		return cmd_reg_t'(r[TOTAL_SIZE-1:0]);
	endfunction

	// read words of the selected macro go into both din fields, nothing else moves
	function automatic cmd_reg_t with_read_data(cmd_reg_t r, chip_data_t d0, chip_data_t d1);
		cmd_reg_t n;
		n = r;
		n.port0.din = d0[r.chip_select];
		n.port1.din = d1[r.chip_select];
		return n;
	endfunction

	task automatic draw_read_data();
		for (int c = 0; c < `SRAMTEST_NUM_CHIPS; c++) begin
			sram_data0_i[c] = $urandom;
			sram_data1_i[c] = $urandom;
		end
	endtask

	task automatic clear_strobes();
		gpio_scan_i      = 1'b0;
		la_in_load_i     = 1'b0;
		gpio_sram_load_i = 1'b0;
		la_sram_load_i   = 1'b0;
	endtask

	task automatic wait_cycle();
		@(posedge clk);
		#2;
	endtask

	// fresh read data every cycle so a capture shows which edge it sampled
	always @(posedge clk) begin
		#2;
		draw_read_data();
	end

	// scan beats load beats capture
	always @(posedge clk) begin
		if (!resetn) begin
			model_q <= '0;
		end else if (gpio_scan_i) begin
			model_q <= {model_q[TOTAL_SIZE-2:0], gpio_in_i};
		end else if (la_in_load_i) begin
			model_q <= la_data_i;
		end else if (gpio_sram_load_i || la_sram_load_i) begin
			model_q <= with_read_data(model_q, sram_data0_i, sram_data1_i);
		end
	end

	always @(posedge clk) begin
		if (!resetn || !gpio_scan_i) begin
			scan_run <= 0;
		end else begin
			scan_run <= (scan_run < TOTAL_SIZE) ? scan_run + 1 : scan_run;
		end
		if (gpio_scan_i) begin
			scan_hist <= {scan_hist[TOTAL_SIZE-2:0], gpio_in_i};
		end
	end

	// per macro: the selected one gets the gated select, every other one reads high
	always_comb begin
		for (int c = 0; c < `SRAMTEST_NUM_CHIPS; c++) begin
			exp_csb0[c] = (c == model_q.chip_select) ? (model_q.port0.csb | global_csb_i) : 1'b1;
			exp_csb1[c] = (c == model_q.chip_select) ? (model_q.port1.csb | global_csb_i) : 1'b1;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			abort_run("timeout: the test sequence did not finish within the cycle limit");
		end
	end

	a_la_data: assert property (@(posedge clk) disable iff (!resetn) la_data_o == model_q)
		else abort_run($sformatf("error: la_data_o is %h, expected %h",
			$sampled(la_data_o), $sampled(model_q)));

	a_gpio: assert property (@(posedge clk) disable iff (!resetn)
		gpio_o == model_q[TOTAL_SIZE-1])
		else abort_run($sformatf("error: gpio_o is %h, expected %h",
			$sampled(gpio_o), $sampled(model_q[TOTAL_SIZE-1])));

	// a bit scanned in leaves through gpio_o after a full register length
	a_gpio_delay: assert property (@(posedge clk) disable iff (!resetn)
		(scan_run >= TOTAL_SIZE) |-> (gpio_o == scan_hist[TOTAL_SIZE-1]))
		else abort_run($sformatf("error: gpio_o is %h, expected %h from the scan history",
			$sampled(gpio_o), $sampled(scan_hist[TOTAL_SIZE-1])));

	a_addr0: assert property (@(posedge clk) disable iff (!resetn) addr0_o == model_q.port0.addr)
		else abort_run($sformatf("error: addr0_o is %h, expected %h",
			$sampled(addr0_o), $sampled(model_q.port0.addr)));

	a_din0: assert property (@(posedge clk) disable iff (!resetn) din0_o == model_q.port0.din)
		else abort_run($sformatf("error: din0_o is %h, expected %h",
			$sampled(din0_o), $sampled(model_q.port0.din)));

	a_web0: assert property (@(posedge clk) disable iff (!resetn) web0_o == model_q.port0.web)
		else abort_run($sformatf("error: web0_o is %h, expected %h",
			$sampled(web0_o), $sampled(model_q.port0.web)));

	a_wmask0: assert property (@(posedge clk) disable iff (!resetn)
		wmask0_o == model_q.port0.wmask)
		else abort_run($sformatf("error: wmask0_o is %h, expected %h",
			$sampled(wmask0_o), $sampled(model_q.port0.wmask)));

	a_csb0: assert property (@(posedge clk) disable iff (!resetn) csb0_o == exp_csb0)
		else abort_run($sformatf("error: csb0_o is %h, expected %h",
			$sampled(csb0_o), $sampled(exp_csb0)));

	a_addr1: assert property (@(posedge clk) disable iff (!resetn) addr1_o == model_q.port1.addr)
		else abort_run($sformatf("error: addr1_o is %h, expected %h",
			$sampled(addr1_o), $sampled(model_q.port1.addr)));

	a_din1: assert property (@(posedge clk) disable iff (!resetn) din1_o == model_q.port1.din)
		else abort_run($sformatf("error: din1_o is %h, expected %h",
			$sampled(din1_o), $sampled(model_q.port1.din)));

	a_web1: assert property (@(posedge clk) disable iff (!resetn) web1_o == model_q.port1.web)
		else abort_run($sformatf("error: web1_o is %h, expected %h",
			$sampled(web1_o), $sampled(model_q.port1.web)));

	a_wmask1: assert property (@(posedge clk) disable iff (!resetn)
		wmask1_o == model_q.port1.wmask)
		else abort_run($sformatf("error: wmask1_o is %h, expected %h",
			$sampled(wmask1_o), $sampled(model_q.port1.wmask)));

	a_csb1: assert property (@(posedge clk) disable iff (!resetn) csb1_o == exp_csb1)
		else abort_run($sformatf("error: csb1_o is %h, expected %h",
			$sampled(csb1_o), $sampled(exp_csb1)));

	initial begin
		void'($urandom(32'hb7));
		cycle_count  = 0;
		resetn       = 1'b0;
		gpio_in_i    = 1'b0;
		la_data_i    = '0;
		global_csb_i = 1'b0;
		clear_strobes();
		draw_read_data();
		repeat (3) @(posedge clk);
		#2;
		resetn = 1'b1;

		// idle after reset, chip 0 csb follows the global select
		for (int i = 0; i < 4; i++) begin
			global_csb_i = i[0];
			wait_cycle();
		end
		global_csb_i = 1'b0;

		for (int i = 0; i < 100; i++) begin
			la_in_load_i = 1'b1;
			la_data_i    = random_cmd();
			wait_cycle();
		end
		clear_strobes();
		wait_cycle();

		// two full scans, the second pushes the first out of gpio_o
		gpio_scan_i = 1'b1;
		for (int i = 0; i < 2 * TOTAL_SIZE; i++) begin
			gpio_in_i = random_bit();
			wait_cycle();
		end
		clear_strobes();

		// field decode with the global select toggling on load and hold cycles
		for (int i = 0; i < 60; i++) begin
			la_in_load_i = 1'b1;
			la_data_i    = random_cmd();
			global_csb_i = random_bit();
			wait_cycle();
			la_in_load_i = 1'b0;
			global_csb_i = random_bit();
			wait_cycle();
		end

		for (int i = 0; i < 40; i++) begin
			la_in_load_i = 1'b1;
			la_data_i    = random_cmd();
			wait_cycle();
			clear_strobes();
			if (i % 2 == 0) begin
				gpio_sram_load_i = 1'b1;
			end else begin
				la_sram_load_i = 1'b1;
			end
			wait_cycle();
			clear_strobes();
		end

		// strobes raised together at random
		for (int i = 0; i < 80; i++) begin
			gpio_scan_i      = random_bit();
			la_in_load_i     = random_bit();
			gpio_sram_load_i = random_bit();
			la_sram_load_i   = random_bit();
			gpio_in_i        = random_bit();
			la_data_i        = random_cmd();
			global_csb_i     = random_bit();
			wait_cycle();
		end
		clear_strobes();
		repeat (3) wait_cycle();

		$display("Simulation passed");
		$finish;
	end

endmodule

/* all.f */
+incdir+.
sramtest_pkg.sv
sramtest_ctrl.sv
sram_port_drive.sv
read_capture_mux.sv
sramtest_top.sv
tb_sramtest.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator, a failing run ends in $fatal
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module tb_sramtest -o sim_tb_sramtest
./obj_dir/sim_tb_sramtest
